// File: common/sprite_macros.svh
// ################################################
// sprite display constants: raster timing, sprite
// geometry, motion and the transparent colour index
// ################################################

`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// horizontal raster, pixels
`define SPR_H_RES       32
`define SPR_H_FP        2
`define SPR_H_SYNC      4
`define SPR_H_BP        2
`define SPR_H_TOTAL     (`SPR_H_RES + `SPR_H_FP + `SPR_H_SYNC + `SPR_H_BP)

// vertical raster, lines
`define SPR_V_RES       24
`define SPR_V_FP        1
`define SPR_V_SYNC      2
`define SPR_V_BP        1
`define SPR_V_TOTAL     (`SPR_V_RES + `SPR_V_FP + `SPR_V_SYNC + `SPR_V_BP)

// sprite bitmap and drawn size
`define SPR_WIDTH       8
`define SPR_HEIGHT      4
`define SPR_SCALE       1                           // shift, 2x
`define SPR_DRAW_W      (`SPR_WIDTH << `SPR_SCALE)
`define SPR_DRAW_H      (`SPR_HEIGHT << `SPR_SCALE)

`define SPR_SPEED       3   // pixels per frame, leftwards
`define SPR_START_Y     8
`define SPR_TRANS_INDX  9   // index drawn as background

`endif

// File: common/sprite_pkg.sv
// ################################################
// shared types for the sprite display pipeline
// ################################################

`include "sprite_macros.svh"

package sprite_pkg;

    typedef logic signed [7:0] coord_t;   // screen coordinate, may go negative
    typedef logic [3:0] cidx_t;           // palette index

    typedef logic [$clog2(`SPR_WIDTH * `SPR_HEIGHT)-1:0] bmp_addr_t;  // 5 bits

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colr_t;

    // host write into the sprite bitmap
    typedef struct packed {
        logic      valid;
        bmp_addr_t addr;
        cidx_t     cidx;
    } bmp_load_t;

    // host write into the palette
    typedef struct packed {
        logic  valid;
        cidx_t addr;
        colr_t colr;
    } pal_load_t;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;
        logic   vsync;
        logic   de;      // active area
        logic   frame;   // first pixel of frame
        logic   line;    // first pixel of line
    } raster_t;

    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        colr_t colr;
    } pix_out_t;

endpackage

// File: hw/display_timing.sv
// ################################################
// raster timing: pixel/line counters, sync, data
// enable and frame/line start pulses
// ################################################

`timescale 1ns/1ps
`include "sprite_macros.svh"

module display_timing (
    input  logic                clk_pix,
    input  logic                rst_pix,
    output sprite_pkg::raster_t raster
);

    sprite_pkg::coord_t sx;  // 0 .. H_TOTAL-1
    sprite_pkg::coord_t sy;  // 0 .. V_TOTAL-1

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == sprite_pkg::coord_t'(`SPR_H_TOTAL - 1));
    assign frame_end = (sy == sprite_pkg::coord_t'(`SPR_V_TOTAL - 1));

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + sprite_pkg::coord_t'(1);  // next line or wrap
        end else begin
            sx <= sx + sprite_pkg::coord_t'(1);
        end
    end

    // outputs straight from the counters
    always_comb begin
        raster.sx = sx;
        raster.sy = sy;
        // active high sync pulses after the front porch
        raster.hsync = (sx >= `SPR_H_RES + `SPR_H_FP) &&
                       (sx <  `SPR_H_RES + `SPR_H_FP + `SPR_H_SYNC);
        raster.vsync = (sy >= `SPR_V_RES + `SPR_V_FP) &&
                       (sy <  `SPR_V_RES + `SPR_V_FP + `SPR_V_SYNC);
        raster.de    = (sx < `SPR_H_RES) && (sy < `SPR_V_RES);
        raster.frame = (sx == '0) && (sy == '0);
        raster.line  = (sx == '0);  // every line including blanking
    end

endmodule

// File: hw/frame_compositor.sv
// ################################################
// compositor: background bands, transparency,
// blanking and sync delay to match the pixel path
// ################################################

`timescale 1ns/1ps
`include "sprite_macros.svh"

module frame_compositor (
    input  logic                 clk_pix,
    input  logic                 rst_pix,
    input  sprite_pkg::raster_t  raster,
    input  sprite_pkg::cidx_t    spr_cidx,
    input  logic                 spr_drawing,
    input  sprite_pkg::colr_t    spr_colr,
    output sprite_pkg::pix_out_t pix_out
);

    localparam sprite_pkg::colr_t BAND_TOP = 12'h239;  // sky
    localparam sprite_pkg::colr_t BAND_MID = 12'h25B;
    localparam sprite_pkg::colr_t BAND_LOW = 12'h260;  // ground

    sprite_pkg::colr_t bg_colr;
    sprite_pkg::colr_t paint_colr;

    logic [2:0] sync_q1;  // {hsync, vsync, de}, raster + 1
    logic [2:0] sync_q2;  // raster + 2
    logic       drawing_q;  // opaque sprite pixel, lines up with spr_colr

    // band latched at line start, steady for the whole line
    always_ff @(posedge clk_pix) begin
        if (raster.line) begin
            if (raster.sy < 8) begin
                bg_colr <= BAND_TOP;
            end else if (raster.sy < 16) begin
                bg_colr <= BAND_MID;
            end else begin
                bg_colr <= BAND_LOW;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            sync_q1   <= '0;
            sync_q2   <= '0;
            drawing_q <= 1'b0;
        end else begin
            sync_q1   <= {raster.hsync, raster.vsync, raster.de};
            sync_q2   <= sync_q1;
            // palette adds a cycle, so qualify here
            drawing_q <= spr_drawing &&
                         (spr_cidx != sprite_pkg::cidx_t'(`SPR_TRANS_INDX));
        end
    end

    // sprite over background
    assign paint_colr = drawing_q ? spr_colr : bg_colr;

    // output register, third stage
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            pix_out <= '0;
        end else begin
            pix_out.hsync <= sync_q2[2];
            pix_out.vsync <= sync_q2[1];
            pix_out.de    <= sync_q2[0];
            pix_out.colr  <= sync_q2[0] ? paint_colr : '0;  // black in blanking
        end
    end

endmodule

// File: hw/palette_lut.sv
// ################################################
// 16-entry palette, host written, registered read
// ################################################

`timescale 1ns/1ps

module palette_lut (
    input  logic                  clk_pix,
    input  sprite_pkg::pal_load_t pal_load,
    input  sprite_pkg::cidx_t     spr_cidx,
    output sprite_pkg::colr_t     spr_colr
);

    localparam int PAL_DEPTH = 2 ** $bits(sprite_pkg::cidx_t);  // one per index

    sprite_pkg::colr_t pal_mem [PAL_DEPTH];  // 12-bit rgb entries

    // write port, no handshake
    always_ff @(posedge clk_pix) begin
        if (pal_load.valid) begin
            pal_mem[pal_load.addr] <= pal_load.colr;
        end
    end

    // read every cycle
    // same-entry write in this cycle is not seen until the next read
    always_ff @(posedge clk_pix) begin
        spr_colr <= pal_mem[spr_cidx];
    end

endmodule

// File: hw/sprite_display_top.sv
// ################################################
// sprite display top: timing, sprite engine,
// palette and compositor
// ################################################

`timescale 1ns/1ps

module sprite_display_top (
    input  logic                  clk_pix,
    input  logic                  rst_pix,
    input  sprite_pkg::bmp_load_t bmp_load,
    input  sprite_pkg::pal_load_t pal_load,
    output sprite_pkg::pix_out_t  pix_out
);

    sprite_pkg::raster_t raster;      // zero latency from counters
    sprite_pkg::cidx_t   spr_cidx;    // raster + 1
    logic                spr_drawing; // raster + 1
    sprite_pkg::colr_t   spr_colr;    // raster + 2

    display_timing u_display_timing (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .raster  (raster)
    );

    sprite_engine u_sprite_engine (
        .clk_pix     (clk_pix),
        .rst_pix     (rst_pix),
        .raster      (raster),
        .bmp_load    (bmp_load),
        .spr_cidx    (spr_cidx),
        .spr_drawing (spr_drawing)
    );

    palette_lut u_palette_lut (
        .clk_pix  (clk_pix),
        .pal_load (pal_load),
        .spr_cidx (spr_cidx),
        .spr_colr (spr_colr)
    );

    // pix_out lands 3 cycles after raster
    frame_compositor u_frame_compositor (
        .clk_pix     (clk_pix),
        .rst_pix     (rst_pix),
        .raster      (raster),
        .spr_cidx    (spr_cidx),
        .spr_drawing (spr_drawing),
        .spr_colr    (spr_colr),
        .pix_out     (pix_out)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the sprite display testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sprite_display_top.f \
    --top-module sprite_display_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vsprite_display_tb > sim.log 2>&1
grep -q "TEST PASSED" sim.log && echo "simulation ok" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sprite/sprite_engine.sv
// ################################################
// sprite engine: per-frame motion, hit test and
// scaled bitmap lookup from a host-loaded bitmap
// ################################################

`timescale 1ns/1ps
`include "sprite_macros.svh"

module sprite_engine (
    input  logic                  clk_pix,
    input  logic                  rst_pix,
    input  sprite_pkg::raster_t   raster,
    input  sprite_pkg::bmp_load_t bmp_load,
    output sprite_pkg::cidx_t     spr_cidx,
    output logic                  spr_drawing
);

    localparam int BMP_DEPTH = `SPR_WIDTH * `SPR_HEIGHT;
    localparam sprite_pkg::coord_t SPR_Y = sprite_pkg::coord_t'(`SPR_START_Y);  // fixed row

    sprite_pkg::coord_t spr_x;  // top left corner of drawn box

    sprite_pkg::cidx_t bmp_mem [BMP_DEPTH];  // host-loaded bitmap

    sprite_pkg::coord_t dx;  // offset inside drawn box
    sprite_pkg::coord_t dy;
    sprite_pkg::coord_t col;  // bitmap column after unscaling
    sprite_pkg::coord_t row;
    sprite_pkg::bmp_addr_t bmp_addr;
    logic hit;

    // x moves once per frame at the frame pulse
    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            spr_x <= sprite_pkg::coord_t'(`SPR_H_RES);    // just off the right edge
        end else if (raster.frame) begin
            if (spr_x <= -(`SPR_DRAW_W)) begin
                spr_x <= sprite_pkg::coord_t'(`SPR_H_RES);  // fully gone so wrap right
            end else begin
                spr_x <= spr_x - sprite_pkg::coord_t'(`SPR_SPEED);
            end
        end
    end

    // hit test and address straight from the raster
    always_comb begin
        dx  = raster.sx - spr_x;
        dy  = raster.sy - SPR_Y;
        hit = (raster.sx >= spr_x) && (raster.sx <= spr_x + (`SPR_DRAW_W - 1)) &&
              (raster.sy >= SPR_Y) && (raster.sy <= SPR_Y + (`SPR_DRAW_H - 1));
        col = dx >>> `SPR_SCALE;  // each bitmap pixel covers 2x2
        row = dy >>> `SPR_SCALE;
        // address outside the box is masked by hit
        bmp_addr = sprite_pkg::bmp_addr_t'(row * `SPR_WIDTH + col);
    end

    // host writes are always accepted
    always_ff @(posedge clk_pix) begin
        if (bmp_load.valid) begin
            bmp_mem[bmp_load.addr] <= bmp_load.cidx;
        end
    end

    // registered read one cycle behind raster
    always_ff @(posedge clk_pix) begin
        spr_cidx <= bmp_mem[bmp_addr];
    end

    always_ff @(posedge clk_pix) begin
        if (rst_pix) begin
            spr_drawing <= 1'b0;
        end else begin
            spr_drawing <= hit;  // aligned with spr_cidx
        end
    end

endmodule

// File: sprite_display_top.f
+incdir+common
common/sprite_pkg.sv
hw/display_timing.sv
sprite/sprite_engine.sv
hw/palette_lut.sv
hw/frame_compositor.sv
hw/sprite_display_top.sv
testbench/sprite_display_checker.sv
testbench/sprite_display_tb.sv

// File: testbench/sprite_display_checker.sv
// ################################################
// output stream assertions, bound into the top
// ################################################

`timescale 1ns/1ps

module sprite_display_checker (
    input logic                 clk_pix,
    input logic                 rst_pix,
    input sprite_pkg::pix_out_t pix_out
);

    // blanking is always black
    blank_is_black: assert property (@(posedge clk_pix) disable iff (rst_pix)
        !pix_out.de |-> (pix_out.colr == '0))
        else $error("colour not zero while de is low");

    // sync sits in the blanking interval only
    hsync_outside_de: assert property (@(posedge clk_pix) disable iff (rst_pix)
        !(pix_out.hsync && pix_out.de))
        else $error("hsync and de high together");

    reset_quiet: assert property (@(posedge clk_pix)
        rst_pix |=> !pix_out.de)  // one edge for the reset to land
        else $error("de high during reset");

endmodule

// File: testbench/sprite_display_input.txt
// 32 bitmap colour indices, row major, 8 per row (index 9 is transparent)
// 16 palette colours as rgb, palette rewrite index and colour, frame count
9 9 1 2 2 1 9 9
9 1 3 4 4 3 1 9
1 3 5 6 6 5 3 1
9 7 9 8 8 9 7 9
000 F00 0F0 00F FF0 0FF F0F 888
FA5 123 456 789 ABC DEF 321 654
3 5A5
014

// File: testbench/sprite_display_tb.sv
// ################################################
// sprite display testbench: loads bitmap/palette,
// tracks the output raster and checks every pixel
// ################################################

`timescale 1ns/1ps
`include "sprite_macros.svh"

module sprite_display_tb;

    localparam int BMP_WORDS     = `SPR_WIDTH * `SPR_HEIGHT;
    localparam int PAL_BASE      = BMP_WORDS;       // 16 palette colours follow the bitmap
    localparam int REWRITE_BASE  = PAL_BASE + 16;   // index, then new colour
    localparam int FRAME_WORD    = REWRITE_BASE + 2;
    localparam int VSYNC_TIMEOUT = 3 * `SPR_H_TOTAL * `SPR_V_TOTAL;
    localparam int DRAW_W        = `SPR_WIDTH << `SPR_SCALE;
    localparam int DRAW_H        = `SPR_HEIGHT << `SPR_SCALE;

    logic                  clk_pix;
    logic                  rst_pix;
    sprite_pkg::bmp_load_t bmp_load;
    sprite_pkg::pal_load_t pal_load;
    sprite_pkg::pix_out_t  pix_out;

    logic [11:0] stim [FRAME_WORD + 1];  // whole input file
    int bmp_model [BMP_WORDS];
    int pal_model [16];
    int px, py, frame_no, model_x, num_frames, rewrite_frame;
    int de_cnt, hs_cnt, vs_cnt, act_lines, wraps, errors;
    bit found, prev_vs;
    sprite_pkg::bmp_load_t bmp_word;
    sprite_pkg::pal_load_t pal_word;

    sprite_display_top DUT (
        .clk_pix  (clk_pix),
        .rst_pix  (rst_pix),
        .bmp_load (bmp_load),
        .pal_load (pal_load),
        .pix_out  (pix_out)
    );

    bind sprite_display_top sprite_display_checker u_checker (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .pix_out (pix_out)
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;  // 50 MHz pixel clock
    end

    function automatic int band_colour(input int y);
        if (y < 8) return 'h239;
        if (y < 16) return 'h25B;
        return 'h260;  // ground band
    endfunction

    // one frame step wraps right once fully off the left edge
    function automatic int next_x(input int x);
        if (x <= -DRAW_W) return `SPR_H_RES;
        return x - `SPR_SPEED;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // compares the current output sample with the model at (px, py)
    task automatic check_pixel();
        string where;
        int    exp_colr;
        int    idx;
        bit    exp_hs;
        bit    exp_vs;
        bit    exp_de;
        where  = $sformatf("f%0d x%0d y%0d", frame_no, px, py);
        exp_hs = (px >= `SPR_H_RES + `SPR_H_FP) && (px < `SPR_H_RES + `SPR_H_FP + `SPR_H_SYNC);
        exp_vs = (py >= `SPR_V_RES + `SPR_V_FP) && (py < `SPR_V_RES + `SPR_V_FP + `SPR_V_SYNC);
        exp_de = (px < `SPR_H_RES) && (py < `SPR_V_RES);
        exp_colr = 0;  // black in blanking
        if (exp_de) begin
            exp_colr = band_colour(py);
            if (px >= model_x && px < model_x + DRAW_W &&
                py >= `SPR_START_Y && py < `SPR_START_Y + DRAW_H) begin
                idx = bmp_model[((py - `SPR_START_Y) >> `SPR_SCALE) * `SPR_WIDTH +
                                ((px - model_x) >> `SPR_SCALE)];
                if (idx != `SPR_TRANS_INDX) exp_colr = pal_model[idx];
            end
        end
        check_value({"hsync ", where}, exp_hs, pix_out.hsync);
        check_value({"vsync ", where}, exp_vs, pix_out.vsync);
        check_value({"de ", where}, exp_de, pix_out.de);
        check_value({"colr ", where}, exp_colr, int'(pix_out.colr));
        de_cnt += pix_out.de;
        hs_cnt += pix_out.hsync;
        vs_cnt += pix_out.vsync;
        if (px == `SPR_H_TOTAL - 1) begin  // line geometry
            if (de_cnt > 0) act_lines++;  // line carried active pixels
            if (py < `SPR_V_RES) begin
                check_value({"de per line ", where}, `SPR_H_RES, de_cnt);
            end
            check_value({"hsync width ", where}, `SPR_H_SYNC, hs_cnt);
            de_cnt = 0;
            hs_cnt = 0;
            if (py == `SPR_V_TOTAL - 1) begin
                if (frame_no >= 1) begin  // frame 0 is only partly seen
                    check_value({"active lines ", where}, `SPR_V_RES, act_lines);
                    check_value({"vsync width ", where}, `SPR_V_SYNC * `SPR_H_TOTAL, vs_cnt);
                end
                act_lines = 0;
                vs_cnt = 0;
            end
        end
    endtask

    task automatic advance_raster();
        if (px == `SPR_H_TOTAL - 1) begin
            px = 0;
            if (py == `SPR_V_TOTAL - 1) begin
                py = 0;
                frame_no++;
                if (model_x <= -DRAW_W) wraps++;
                model_x = next_x(model_x);  // frame pulse
            end else begin
                py++;
            end
        end else begin
            px++;
        end
    endtask

    initial begin
        rst_pix  = 1'b1;
        bmp_load = '0;
        pal_load = '0;
        errors   = 0;
        $readmemh("testbench/sprite_display_input.txt", stim);
        num_frames = int'(stim[FRAME_WORD]);
        if (num_frames < 1) begin
            $display("input file missing or frame count is zero");
            $display("TEST FAILED");
            $fatal(1, "no stimulus");
        end
        rewrite_frame = num_frames / 2;
        for (int k = 0; k < BMP_WORDS; k++) bmp_model[k] = int'(stim[k]);
        for (int k = 0; k < 16; k++) pal_model[k] = int'(stim[PAL_BASE + k]);

        // output must stay quiet through reset, the eighth edge releases it
        for (int k = 0; k < 7; k++) begin
            @(posedge clk_pix);
            @(negedge clk_pix);
            check_value("reset pix_out", 0, int'(pix_out));
        end
        @(posedge clk_pix);
        rst_pix <= 1'b0;

        // host load while the pipeline fills
        for (int k = 0; k < BMP_WORDS; k++) begin
            @(negedge clk_pix);
            if (k < 3) check_value("pipeline fill pix_out", 0, int'(pix_out));
            @(posedge clk_pix);
            bmp_word = '{valid: 1'b1, addr: sprite_pkg::bmp_addr_t'(k),
                         cidx: sprite_pkg::cidx_t'(stim[k])};
            pal_word = '{valid: (k < 16), addr: sprite_pkg::cidx_t'(k),
                         colr: sprite_pkg::colr_t'(stim[PAL_BASE + (k % 16)])};
            bmp_load <= bmp_word;
            pal_load <= pal_word;
        end
        @(posedge clk_pix);
        bmp_load <= '0;
        pal_load <= '0;

        // lock onto the output raster at the first vsync edge
        found   = 1'b0;
        prev_vs = 1'b0;
        for (int t = 0; t < VSYNC_TIMEOUT && !found; t++) begin
            @(negedge clk_pix);
            if (pix_out.vsync && !prev_vs) found = 1'b1;
            prev_vs = pix_out.vsync;
        end
        if (!found) begin
            $display("timeout: no vsync rising edge seen on pix_out");
            $display("TEST FAILED");
            $fatal(1, "no frame start");
        end

        px        = 0;
        py        = `SPR_V_RES + `SPR_V_FP;  // first vsync line
        frame_no  = 0;
        model_x   = next_x(`SPR_H_RES);      // frame 0 already stepped
        wraps     = 0;
        de_cnt    = 0;
        hs_cnt    = 0;
        vs_cnt    = 0;
        act_lines = 0;
        while (frame_no <= num_frames) begin
            check_pixel();
            @(posedge clk_pix);
            pal_load <= '0;
            if (frame_no == rewrite_frame && py == `SPR_V_RES + `SPR_V_FP + 1 && px == 0) begin
                // palette change in vblank shows from the next frame
                pal_word = '{valid: 1'b1, addr: sprite_pkg::cidx_t'(stim[REWRITE_BASE]),
                             colr: sprite_pkg::colr_t'(stim[REWRITE_BASE + 1])};
                pal_load <= pal_word;
                pal_model[int'(stim[REWRITE_BASE]) % 16] = int'(stim[REWRITE_BASE + 1]);
            end
            advance_raster();
            @(negedge clk_pix);
        end
        check_value("sprite wrap covered", 1, int'(wraps > 0));

        if (errors == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule
